/* eth_csum_insert.sv */
`timescale 1ns/10ps

module eth_csum_insert (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] s_tdata,
	input  logic s_tlast,
	input  logic s_tvalid,
	input  logic [15:0] s_csum_val,
	input  logic [eth_loop_pkg::CSUM_POS_W-1:0] s_csum_pos,
	output logic s_tready,
	output logic [7:0] m_tdata,
	output logic m_tlast,
	output logic m_tvalid,
	input  logic m_tready
);
	import eth_loop_pkg::*;

	// offset of the byte now on the bus
	logic [CSUM_POS_W-1:0] pos_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pos_cnt <= '0;
		end else if (s_tvalid && m_tready) begin
			pos_cnt <= s_tlast ? '0 : pos_cnt + 1'b1;
		end
	end

	assign s_tready = m_tready;
	assign m_tvalid = s_tvalid;
	assign m_tlast = s_tlast;

	// zero value means no checksum applies
	always_comb begin
		m_tdata = s_tdata;
		if (s_csum_val != 16'd0) begin
			if (pos_cnt == s_csum_pos - CSUM_POS_W'(1)) begin
				m_tdata = s_csum_val[15:8];
			end else if (pos_cnt == s_csum_pos) begin
				m_tdata = s_csum_val[7:0];
			end
		end
	end

endmodule

/* eth_frame_buffer.sv */
`timescale 1ns/10ps

module eth_frame_buffer (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] s_tdata,
	input  logic s_tlast,
	input  logic s_tvalid,
	input  logic s_drop,
	input  logic s_fcs_invalid,
	input  logic [15:0] s_csum_val,
	input  logic [eth_loop_pkg::CSUM_POS_W-1:0] s_csum_pos,
	output logic overflow,
	output logic [7:0] m_tdata,
	output logic m_tlast,
	output logic m_tvalid,
	output logic [15:0] m_csum_val,
	output logic [eth_loop_pkg::CSUM_POS_W-1:0] m_csum_pos,
	input  logic m_tready
);
	import eth_loop_pkg::*;

	logic [7:0] mem [BUF_DEPTH];

	// pointers carry one extra bit to tell full from empty
	logic [BUF_AW:0] wr_ptr;
	logic [BUF_AW:0] wr_start;
	logic [BUF_AW:0] rd_ptr;
	logic [BUF_AW:0] fill;
	logic room;
	logic ovf_flag;
	logic bad;
	logic lost;
	logic wr_en;
	logic commit;

	logic [BUF_AW-1:0] meta_end [META_DEPTH];
	logic [15:0] meta_val [META_DEPTH];
	logic [CSUM_POS_W-1:0] meta_pos [META_DEPTH];
	logic [$clog2(META_DEPTH):0] meta_wr;
	logic [$clog2(META_DEPTH):0] meta_rd;
	logic [$clog2(META_DEPTH):0] meta_fill;
	logic meta_full;
	logic meta_empty;

	logic active;
	logic [BUF_AW-1:0] cur_end;
	logic pop;
	logic load;
	logic rd_last;

	always_comb begin
		fill = wr_ptr - rd_ptr;
		room = !fill[BUF_AW];
		meta_fill = meta_wr - meta_rd;
		meta_full = meta_fill[$clog2(META_DEPTH)];
		meta_empty = (meta_wr == meta_rd);

		bad = s_drop || s_fcs_invalid;
		lost = ovf_flag || !room || meta_full;
		wr_en = s_tvalid && room && !ovf_flag;
		commit = s_tvalid && s_tlast && !bad && !lost;

		// next frame starts once the last byte has left the output stage
		pop = !active && !meta_empty && (!m_tvalid || m_tready);
		load = active && (!m_tvalid || m_tready);
		rd_last = (rd_ptr[BUF_AW-1:0] == cur_end);
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr[BUF_AW-1:0]] <= s_tdata;
		end
		if (commit) begin
			meta_end[meta_wr[$clog2(META_DEPTH)-1:0]] <= wr_ptr[BUF_AW-1:0];
			meta_val[meta_wr[$clog2(META_DEPTH)-1:0]] <= s_csum_val;
			meta_pos[meta_wr[$clog2(META_DEPTH)-1:0]] <= s_csum_pos;
		end
	end

	// write side, speculative until the last byte
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			wr_start <= '0;
			meta_wr <= '0;
			ovf_flag <= 1'b0;
			overflow <= 1'b0;
		end else begin
			overflow <= 1'b0;
			if (s_tvalid) begin
				if (!s_tlast) begin
					if (wr_en) begin
						wr_ptr <= wr_ptr + 1'b1;
					end else begin
						ovf_flag <= 1'b1;
					end
				end else if (commit) begin
					wr_ptr <= wr_ptr + 1'b1;
					wr_start <= wr_ptr + 1'b1;
					meta_wr <= meta_wr + 1'b1;
				end else begin
					wr_ptr <= wr_start;
					ovf_flag <= 1'b0;
					overflow <= lost && !bad;
				end
			end
		end
	end

	// read side
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			meta_rd <= '0;
			active <= 1'b0;
			m_tvalid <= 1'b0;
			m_tlast <= 1'b0;
		end else begin
			if (pop) begin
				meta_rd <= meta_rd + 1'b1;
				active <= 1'b1;
			end
			if (load) begin
				rd_ptr <= rd_ptr + 1'b1;
				m_tvalid <= 1'b1;
				m_tlast <= rd_last;
				if (rd_last) begin
					active <= 1'b0;
				end
			end else if (m_tready) begin
				m_tvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			cur_end <= meta_end[meta_rd[$clog2(META_DEPTH)-1:0]];
			m_csum_val <= meta_val[meta_rd[$clog2(META_DEPTH)-1:0]];
			m_csum_pos <= meta_pos[meta_rd[$clog2(META_DEPTH)-1:0]];
		end
		if (load) begin
			m_tdata <= mem[rd_ptr[BUF_AW-1:0]];
		end
	end

endmodule

/* eth_frame_loop.f */
eth_loop_pkg.sv
eth_frame_loop_csum.sv
eth_frame_buffer.sv
eth_csum_insert.sv
eth_frame_loop.sv
tb_eth_frame_loop.sv

/* eth_frame_loop.sv */
`timescale 1ns/10ps

module eth_frame_loop (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] rx_tdata,
	// {drop, fcs_invalid}
	input  logic [1:0] rx_tuser,
	input  logic rx_tlast,
	input  logic rx_tvalid,
	output logic [7:0] tx_tdata,
	output logic tx_tlast,
	output logic tx_tvalid,
	input  logic tx_tready,
	output logic rx_overflow
);
	import eth_loop_pkg::*;

	// checksum block to frame store
	logic [7:0] cs_tdata;
	logic cs_tlast;
	logic cs_tvalid;
	logic cs_drop;
	logic cs_fcs_invalid;
	logic [15:0] cs_csum_val;
	logic [CSUM_POS_W-1:0] cs_csum_pos;

	// frame store to inserter
	logic [7:0] bf_tdata;
	logic bf_tlast;
	logic bf_tvalid;
	logic bf_tready;
	logic [15:0] bf_csum_val;
	logic [CSUM_POS_W-1:0] bf_csum_pos;

	eth_frame_loop_csum u_csum (
		.clk(clk),
		.rst_n(rst_n),
		.s_tdata(rx_tdata),
		.s_tuser(rx_tuser),
		.s_tlast(rx_tlast),
		.s_tvalid(rx_tvalid),
		.m_tdata(cs_tdata),
		.m_tlast(cs_tlast),
		.m_tvalid(cs_tvalid),
		.m_drop(cs_drop),
		.m_fcs_invalid(cs_fcs_invalid),
		.m_csum_val(cs_csum_val),
		.m_csum_pos(cs_csum_pos)
	);

	eth_frame_buffer u_buf (
		.clk(clk),
		.rst_n(rst_n),
		.s_tdata(cs_tdata),
		.s_tlast(cs_tlast),
		.s_tvalid(cs_tvalid),
		.s_drop(cs_drop),
		.s_fcs_invalid(cs_fcs_invalid),
		.s_csum_val(cs_csum_val),
		.s_csum_pos(cs_csum_pos),
		.overflow(rx_overflow),
		.m_tdata(bf_tdata),
		.m_tlast(bf_tlast),
		.m_tvalid(bf_tvalid),
		.m_csum_val(bf_csum_val),
		.m_csum_pos(bf_csum_pos),
		.m_tready(bf_tready)
	);

	eth_csum_insert u_ins (
		.clk(clk),
		.rst_n(rst_n),
		.s_tdata(bf_tdata),
		.s_tlast(bf_tlast),
		.s_tvalid(bf_tvalid),
		.s_csum_val(bf_csum_val),
		.s_csum_pos(bf_csum_pos),
		.s_tready(bf_tready),
		.m_tdata(tx_tdata),
		.m_tlast(tx_tlast),
		.m_tvalid(tx_tvalid),
		.m_tready(tx_tready)
	);

endmodule

/* eth_frame_loop_csum.sv */
`timescale 1ns/10ps

module eth_frame_loop_csum (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] s_tdata,
	// {drop, fcs_invalid}
	input  logic [1:0] s_tuser,
	input  logic s_tlast,
	input  logic s_tvalid,
	output logic [7:0] m_tdata,
	output logic m_tlast,
	output logic m_tvalid,
	output logic m_drop,
	output logic m_fcs_invalid,
	output logic [15:0] m_csum_val,
	output logic [eth_loop_pkg::CSUM_POS_W-1:0] m_csum_pos
);
	import eth_loop_pkg::*;

	logic [15:0] cnt;
	logic [7:0] prev;
	logic [1:0] proto;
	logic hdr_ok;
	logic done;
	logic [15:0] data_begin;
	logic [15:0] data_end;
	logic [CSUM_POS_W-1:0] csum_pos;
	logic [15:0] acc;
	logic [15:0] result;

	logic frame_end;
	logic at_end;
	logic fin;
	logic proto_byte;
	logic proto_hit;
	logic [4:0] pos_off;
	logic hdr_add;
	logic data_add;
	logic add_en;
	logic [15:0] hdr_len;
	logic [15:0] word;
	logic [16:0] sum17;
	logic [15:0] folded;
	logic [15:0] sum_in;
	logic [15:0] csum_fin;

	always_comb begin
		frame_end = s_tvalid && s_tlast;
		// last byte of the ip data span
		at_end = (data_end != 16'd0) && (cnt == data_end);
		fin = s_tlast || at_end;
		hdr_len = {10'd0, s_tdata[3:0], 2'b00};

		proto_byte = (proto == PROTO_IPV4 && cnt == 16'd23) ||
			(proto == PROTO_IPV6 && cnt == 16'd20);

		// checksum offset from the start of the transport header, plus one
		proto_hit = 1'b1;
		pos_off = 5'd0;
		case (s_tdata)
			IPPROTO_TCP: pos_off = 5'd17;
			IPPROTO_UDP: pos_off = 5'd7;
			IPPROTO_ICMP: begin
				pos_off = 5'd3;
				proto_hit = (proto == PROTO_IPV4);
			end
			IPPROTO_ICMPV6: begin
				pos_off = 5'd3;
				proto_hit = (proto == PROTO_IPV6);
			end
			default: proto_hit = 1'b0;
		endcase

		// pseudo-header words, summed on the second byte of each pair
		hdr_add = (proto == PROTO_IPV4 && (cnt == 16'd17 || cnt == 16'd23 ||
				(cnt >= 16'd27 && cnt <= 16'd33 && cnt[0]))) ||
			(proto == PROTO_IPV6 && (cnt == 16'd19 || cnt == 16'd20 ||
				(cnt >= 16'd23 && cnt <= 16'd53 && cnt[0])));

		// transport data, skipping the checksum field itself
		data_add = hdr_ok && !done && cnt >= data_begin && (cnt[0] || fin) &&
			cnt != 16'(csum_pos);

		add_en = s_tvalid && (hdr_add || data_add);

		// odd trailing byte is padded with zero
		if (fin && !cnt[0]) begin
			word = {s_tdata, 8'h00};
		end else begin
			word = {prev, s_tdata};
		end

		sum17 = {1'b0, acc} + {1'b0, word};
		folded = sum17[15:0] + {15'd0, sum17[16]};
		sum_in = add_en ? folded : acc;
		// never send an all-zero checksum
		csum_fin = (sum_in == 16'hFFFF) ? 16'hFFFF : ~sum_in;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || frame_end) begin
			cnt <= 16'd0;
			prev <= 8'h00;
			proto <= PROTO_UNKNOWN;
			hdr_ok <= 1'b0;
			done <= 1'b0;
			data_begin <= 16'd0;
			data_end <= 16'd0;
			csum_pos <= '0;
			acc <= 16'd0;
			result <= 16'd0;
		end else if (s_tvalid) begin
			cnt <= cnt + 16'd1;

			// ttl and the byte before next header pair the protocol with zero
			if ((proto == PROTO_IPV4 && cnt == 16'd22) ||
				(proto == PROTO_IPV6 && cnt == 16'd19)) begin
				prev <= 8'h00;
			end else begin
				prev <= s_tdata;
			end

			if (add_en) begin
				acc <= folded;
			end

			if (at_end) begin
				done <= 1'b1;
				result <= csum_fin;
			end

			if (cnt == 16'd13) begin
				if ({prev, s_tdata} == ETHERTYPE_IPV4) begin
					proto <= PROTO_IPV4;
				end else if ({prev, s_tdata} == ETHERTYPE_IPV6) begin
					proto <= PROTO_IPV6;
					data_begin <= 16'd54;
				end
			end

			if (proto == PROTO_IPV4) begin
				// start from minus the header length, total length follows
				if (cnt == 16'd14) begin
					acc <= ~hdr_len;
					data_begin <= 16'd14 + hdr_len;
				end
				if (cnt == 16'd17) begin
					data_end <= {prev, s_tdata} + 16'd13;
				end
			end

			if (proto == PROTO_IPV6 && cnt == 16'd19) begin
				data_end <= {prev, s_tdata} + 16'd53;
			end

			if (proto_byte) begin
				hdr_ok <= proto_hit;
				csum_pos <= data_begin[CSUM_POS_W-1:0] + CSUM_POS_W'(pos_off);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m_tvalid <= 1'b0;
			m_tlast <= 1'b0;
		end else begin
			m_tvalid <= s_tvalid;
			m_tlast <= frame_end;
		end
	end

	// side fields only change on the last beat
	always_ff @(posedge clk) begin
		m_tdata <= s_tdata;
		if (frame_end) begin
			m_drop <= s_tuser[1];
			m_fcs_invalid <= s_tuser[0];
			m_csum_pos <= csum_pos;
			if (!hdr_ok) begin
				m_csum_val <= 16'd0;
			end else if (done) begin
				m_csum_val <= result;
			end else begin
				m_csum_val <= csum_fin;
			end
		end
	end

endmodule

/* eth_loop_pkg.sv */
package eth_loop_pkg;

	// frame store size in bytes
	localparam int BUF_DEPTH = 2048;
	localparam int BUF_AW = 11;

	// committed frames that can wait for replay
	localparam int META_DEPTH = 4;

	// ethertypes
	localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
	localparam logic [15:0] ETHERTYPE_IPV6 = 16'h86DD;

	// ip protocol and ipv6 next header numbers
	localparam logic [7:0] IPPROTO_ICMP = 8'd1;
	localparam logic [7:0] IPPROTO_TCP = 8'd6;
	localparam logic [7:0] IPPROTO_UDP = 8'd17;
	localparam logic [7:0] IPPROTO_ICMPV6 = 8'd58;

	// network layer seen by the checksum block
	localparam logic [1:0] PROTO_UNKNOWN = 2'd0;
	localparam logic [1:0] PROTO_IPV4 = 2'd1;
	localparam logic [1:0] PROTO_IPV6 = 2'd2;

	// frame offset of the second checksum byte
	localparam int CSUM_POS_W = 15;

endpackage

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f eth_frame_loop.f \
	--top-module tb_eth_frame_loop -o sim
./obj_dir/sim > sim.log 2>&1 || true
cat sim.log
if grep -q "RESULT: PASS" sim.log; then
	exit 0
else
	exit 1
fi

/* tb_eth_frame_loop.sv */
`timescale 1ns/10ps

module tb_eth_frame_loop;
	import eth_loop_pkg::*;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic [7:0] rx_tdata;
	logic [1:0] rx_tuser;
	logic rx_tlast;
	logic rx_tvalid;
	logic [7:0] tx_tdata;
	logic tx_tlast;
	logic tx_tvalid;
	logic tx_tready = 1'b1;
	logic rx_overflow;

	integer seed = 32'h26b8;
	bit stalled = 1'b0;
	int held_frames;
	int held_bytes;
	int ovf_cnt = 0;
	int exp_ovf = 0;
	logic [7:0] frm[$];
	logic [7:0] expd[$];
	logic [7:0] exp_q[$];
	bit exp_last[$];

	eth_frame_loop u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.rx_tdata(rx_tdata),
		.rx_tuser(rx_tuser),
		.rx_tlast(rx_tlast),
		.rx_tvalid(rx_tvalid),
		.tx_tdata(tx_tdata),
		.tx_tlast(tx_tlast),
		.tx_tvalid(tx_tvalid),
		.tx_tready(tx_tready),
		.rx_overflow(rx_overflow)
	);

	always #4 clk = ~clk;

	// tx sink takes about three bytes in four unless stalled
	always @(negedge clk) begin
		tx_tready <= !stalled && (($random(seed) & 3) != 0);
	end

	task automatic stop_run();
		$display("RESULT: FAIL");
		$fatal(1, "testbench stopped at the first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
		if (got !== want) begin
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, want);
			stop_run();
		end
	endtask

	task automatic check_last(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("Fail at %0t: %s got %b expected %b", $time, name, got, want);
			stop_run();
		end
	endtask

	function automatic logic [7:0] rand_byte();
		return 8'($random(seed));
	endfunction

	// random bytes with the ethertype and ip header fields filled in
	function automatic void build_frame(input logic [1:0] kind, input logic [7:0] proto,
			input int plen);
		int hl;
		int pad;
		int i;
		logic [15:0] et;
		hl = (kind == PROTO_IPV4) ? 20 : (kind == PROTO_IPV6) ? 40 : 0;
		et = (kind == PROTO_IPV4) ? ETHERTYPE_IPV4 :
			(kind == PROTO_IPV6) ? ETHERTYPE_IPV6 : 16'h88B5;
		// trailer bytes after the ip data on some frames
		pad = (kind == PROTO_UNKNOWN) ? 0 : $unsigned($random(seed)) % 4;
		frm.delete();
		for (i = 0; i < 14 + hl + plen + pad; i++) begin
			frm.push_back(rand_byte());
		end
		frm[12] = et[15:8];
		frm[13] = et[7:0];
		if (kind == PROTO_IPV4) begin
			frm[14] = 8'h45;
			frm[16] = 8'((hl + plen) >> 8);
			frm[17] = 8'(hl + plen);
			frm[23] = proto;
		end else if (kind == PROTO_IPV6) begin
			frm[14] = 8'h60;
			frm[18] = 8'(plen >> 8);
			frm[19] = 8'(plen);
			frm[20] = proto;
		end
	endfunction

	// expected tx frame with the checksum over pseudo-header and transport data
	function automatic void ref_frame();
		int ip;
		int tlen;
		int pos;
		int sum;
		int i;
		logic [7:0] nh;
		logic [7:0] b;
		logic [15:0] csum;
		expd = frm;
		pos = -1;
		sum = 0;
		if ({frm[12], frm[13]} == ETHERTYPE_IPV4) begin
			ip = 14 + 4 * int'(frm[14][3:0]);
			tlen = int'({frm[16], frm[17]}) - (ip - 14);
			nh = frm[23];
			for (i = 26; i < 34; i += 2) begin
				sum += int'({frm[i], frm[i + 1]});
			end
			if (nh == IPPROTO_ICMP) begin
				pos = 2;
			end
		end else if ({frm[12], frm[13]} == ETHERTYPE_IPV6) begin
			ip = 54;
			tlen = int'({frm[18], frm[19]});
			nh = frm[20];
			for (i = 22; i < 54; i += 2) begin
				sum += int'({frm[i], frm[i + 1]});
			end
			if (nh == IPPROTO_ICMPV6) begin
				pos = 2;
			end
		end else begin
			return;
		end
		if (nh == IPPROTO_TCP) begin
			pos = 16;
		end else if (nh == IPPROTO_UDP) begin
			pos = 6;
		end
		if (pos < 0) begin
			return;
		end
		sum += tlen + int'(nh);
		// odd last byte lands in the high half with zero below
		for (i = 0; i < tlen; i++) begin
			b = (i == pos || i == pos + 1) ? 8'h00 : frm[ip + i];
			sum += i[0] ? int'(b) : int'(b) << 8;
		end
		while (sum > 32'hFFFF) begin
			sum = (sum & 32'hFFFF) + (sum >> 16);
		end
		csum = ~sum[15:0];
		if (csum == 16'h0000) begin
			csum = 16'hFFFF;
		end
		expd[ip + pos] = csum[15:8];
		expd[ip + pos + 1] = csum[7:0];
	endfunction

	task automatic run_frame(input logic [1:0] kind, input logic [7:0] proto, input int plen,
			input logic [1:0] user);
		int n;
		int i;
		bit keep;
		build_frame(kind, proto, plen);
		ref_frame();
		n = frm.size();
		keep = (user == 2'b00);
		// first frame of a stall is already replaying while the rest wait in the queue
		if (stalled && keep) begin
			if (held_frames > META_DEPTH || held_bytes + n > BUF_DEPTH) begin
				keep = 1'b0;
				exp_ovf++;
			end else begin
				held_frames++;
				held_bytes += n;
			end
		end
		if (keep) begin
			for (i = 0; i < n; i++) begin
				exp_q.push_back(expd[i]);
				exp_last.push_back(i == n - 1);
			end
		end
		for (i = 0; i < n; i++) begin
			@(negedge clk);
			rx_tdata = frm[i];
			rx_tuser = user;
			rx_tlast = (i == n - 1);
			rx_tvalid = 1'b1;
		end
	endtask

	task automatic idle();
		@(negedge clk);
		rx_tvalid = 1'b0;
		rx_tlast = 1'b0;
	endtask

	task automatic wait_pending(input int limit);
		int t;
		t = 0;
		while (exp_q.size() > limit) begin
			@(posedge clk);
			t++;
			if (t > 20000) begin
				$display("timeout: %0d expected tx bytes never arrived", exp_q.size());
				stop_run();
			end
		end
	endtask

	task automatic stall_burst(input int count, input int plen);
		int k;
		wait_pending(0);
		stalled = 1'b1;
		held_frames = 0;
		held_bytes = 0;
		repeat (2) @(negedge clk);
		for (k = 0; k < count; k++) begin
			run_frame(PROTO_IPV4, IPPROTO_UDP, plen + k, 2'b00);
		end
		idle();
		stalled = 1'b0;
		wait_pending(0);
	endtask

	// every tx transfer against the head of the expected stream
	always @(posedge clk) begin
		if (rst_n && tx_tvalid && tx_tready) begin
			if (exp_q.size() == 0) begin
				$display("tx sent a byte at %0t while no frame was expected", $time);
				stop_run();
			end else begin
				check_byte("tx_tdata", tx_tdata, exp_q.pop_front());
				check_last("tx_tlast", tx_tlast, exp_last.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		if (rst_n && rx_overflow) begin
			ovf_cnt++;
		end
	end

	initial begin
		int k;
		int sel;
		int plen;
		int pick;
		rx_tdata = 8'h00;
		rx_tuser = 2'b00;
		rx_tlast = 1'b0;
		rx_tvalid = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// mixed traffic with a few frames in flight at most
		for (k = 0; k < 60; k++) begin
			sel = $unsigned($random(seed)) % 10;
			plen = 20 + $unsigned($random(seed)) % 90;
			pick = $unsigned($random(seed)) % 3;
			case (sel)
				0, 1, 2: run_frame(PROTO_IPV4, pick == 0 ? IPPROTO_UDP :
					pick == 1 ? IPPROTO_TCP : IPPROTO_ICMP, plen, 2'b00);
				3, 4, 5: run_frame(PROTO_IPV6, pick == 0 ? IPPROTO_UDP :
					pick == 1 ? IPPROTO_TCP : IPPROTO_ICMPV6, plen, 2'b00);
				6: run_frame(PROTO_UNKNOWN, 8'h00, plen + 26, 2'b00);
				7: run_frame(PROTO_IPV4, pick == 0 ? IPPROTO_ICMPV6 : 8'd47, plen, 2'b00);
				8: run_frame(PROTO_IPV6, pick == 0 ? IPPROTO_ICMP : 8'd50, plen, 2'b00);
				// drop, fcs_invalid or both
				default: run_frame(PROTO_IPV4, IPPROTO_UDP, plen, 2'(1 + pick));
			endcase
			idle();
			wait_pending(120);
		end

		// more frames than the queue holds and then more bytes than the store holds
		stall_burst(META_DEPTH + 3, 40);
		stall_burst(4, BUF_DEPTH / 3 - 80);

		repeat (50) @(posedge clk);
		if (ovf_cnt != exp_ovf) begin
			$display("Fail at %0t: rx_overflow pulses %0d expected %0d", $time, ovf_cnt,
				exp_ovf);
			stop_run();
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule
